// File: src/core_out_pkg.sv
////////////////////
// core output package
// raster and audio constants, and the vector types
// shared by the video, audio and synchronizer blocks
////////////////////

`default_nettype none

package core_out_pkg;

    ////////////////////
    // vector types
    ////////////////////

    // raster position, wide enough for 1001 columns
    typedef logic [9:0]  coord_t;

    // emulator pixel
    // [11:8] red, [7:4] green, [3:0] blue
    typedef logic [11:0] pixel12_t;

    // scaler video word, one byte per colour
    typedef logic [23:0] rgb24_t;

    // signed pcm sample
    typedef logic signed [15:0] sample_t;

    // controller key bitmap
    typedef logic [31:0] key_t;

    // rtc word, valid bit on top of the bcd time
    typedef logic [32:0] rtc_word_t;

    // bit position within one i2s channel
    typedef logic [4:0]  aud_bit_cnt_t;

    ////////////////////
    // video raster
    ////////////////////

    localparam coord_t VID_H_TOTAL   = 10'd1001;
    localparam coord_t VID_V_TOTAL   = 10'd333;
    // first active column and line
    localparam coord_t VID_H_BPORCH  = 10'd10;
    localparam coord_t VID_V_BPORCH  = 10'd10;
    localparam coord_t VID_H_ACTIVE  = 10'd256;
    localparam coord_t VID_V_ACTIVE  = 10'd256;
    // hs a few clocks after vs, never on the same cycle
    localparam coord_t VID_HS_COLUMN = 10'd3;

    ////////////////////
    // audio framing
    ////////////////////

    localparam int AUD_BITS_PER_CHANNEL = 32;
    localparam int AUD_SAMPLE_BITS      = 16;

endpackage

`default_nettype wire

// File: src/sync_3.sv
////////////////////
// three stage synchronizer
// carries an asynchronous word into the mclk domain
////////////////////

`timescale 1ns/10ps
`default_nettype none

module sync_3 #(
    parameter int WIDTH = 32
) (
    input  logic             audgen_mclk,
    input  logic             reset_n,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    // first two stages, q is the third
    logic [WIDTH-1:0] stage_1;
    logic [WIDTH-1:0] stage_2;

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            stage_1 <= '0;
            stage_2 <= '0;
            q       <= '0;
        end else begin
            // metastable capture
            stage_1 <= d;
            stage_2 <= stage_1;
            q       <= stage_2;
        end
    end

endmodule

`default_nettype wire

// File: src/video_timing.sv
////////////////////
// video raster timing
// column and line counters, sync pulses and
// the active window flag, all registered
////////////////////

`timescale 1ns/10ps
`default_nettype none

module video_timing (
    input  logic audgen_mclk,
    input  logic reset_n,
    output logic raw_vs,
    output logic raw_hs,
    output logic raw_active
);

    import core_out_pkg::*;

    // raster position
    coord_t x_count;
    coord_t y_count;

    // end of line / end of frame
    logic   x_last;
    logic   y_last;

    // window decode
    logic   x_in_window;
    logic   y_in_window;

    assign x_last = (x_count == coord_t'(VID_H_TOTAL - 10'd1));
    assign y_last = (y_count == coord_t'(VID_V_TOTAL - 10'd1));

    // back porch up to back porch plus active, end exclusive
    assign x_in_window = (x_count >= VID_H_BPORCH) &&
                         (x_count <  coord_t'(VID_H_BPORCH + VID_H_ACTIVE));
    assign y_in_window = (y_count >= VID_V_BPORCH) &&
                         (y_count <  coord_t'(VID_V_BPORCH + VID_V_ACTIVE));

    ////////////////////
    // raster counters
    ////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
            y_count <= '0;
        end else begin
            if (x_last) begin
                x_count <= '0;
                // line advance, wraps at frame end
                if (y_last) begin
                    y_count <= '0;
                end else begin
                    y_count <= y_count + 10'd1;
                end
            end else begin
                x_count <= x_count + 10'd1;
            end
        end
    end

    ////////////////////
    // registered decode
    ////////////////////

    // every output lands one clock after the count it decodes
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            raw_vs     <= 1'b0;
            raw_hs     <= 1'b0;
            raw_active <= 1'b0;
        end else begin
            // frame start at the origin
            raw_vs     <= (x_count == '0) && (y_count == '0);
            // line start, every line
            raw_hs     <= (x_count == VID_HS_COLUMN);
            // data enable region
            raw_active <= x_in_window && y_in_window;
        end
    end

endmodule

`default_nettype wire

// File: src/pixel_output.sv
////////////////////
// pixel output stage
// expands the 12 bit pixel to rgb24 and keeps
// syncs and data enable aligned for the scaler
////////////////////

`timescale 1ns/10ps
`default_nettype none

module pixel_output (
    input  logic                 audgen_mclk,
    input  logic                 reset_n,
    input  logic                 raw_vs,
    input  logic                 raw_hs,
    input  logic                 raw_active,
    input  core_out_pkg::pixel12_t pixel,
    output logic                 video_vs,
    output logic                 video_hs,
    output logic                 video_de,
    output core_out_pkg::rgb24_t video_rgb
);

    import core_out_pkg::*;

    // captured emulator pixel
    pixel12_t pixel_q;
    // nibble to upper nibble of each byte
    rgb24_t   pixel_rgb;

    assign pixel_rgb = {pixel_q[11:8], 4'h0, pixel_q[7:4], 4'h0, pixel_q[3:0], 4'h0};

    // pixel taken on every edge
    always_ff @(posedge audgen_mclk) begin
        pixel_q <= pixel;
    end

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_vs  <= 1'b0;
            video_hs  <= 1'b0;
            video_de  <= 1'b0;
            video_rgb <= '0;
        end else begin
            // same one clock delay on all of them
            video_vs <= raw_vs;
            video_hs <= raw_hs;
            video_de <= raw_active;
            // black outside the window
            if (raw_active) begin
                video_rgb <= pixel_rgb;
            end else begin
                video_rgb <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/i2s_serializer.sv
////////////////////
// i2s serializer
// sclk is mclk / 4, 32 bit slots per channel,
// 16 sample bits msb first after a one bit delay
////////////////////

`timescale 1ns/10ps
`default_nettype none

module i2s_serializer (
    input  logic                  audgen_mclk,
    input  logic                  reset_n,
    input  core_out_pkg::sample_t sample_left,
    input  core_out_pkg::sample_t sample_right,
    output logic                  sample_req,
    output logic                  audio_sclk,
    output logic                  audio_lrck,
    output logic                  audio_dac
);

    import core_out_pkg::*;

    // mclk divider, msb is sclk
    logic [1:0]   mclk_div;
    // falling sclk edge on the next clock
    logic         sclk_fall;

    aud_bit_cnt_t bit_cnt;
    aud_bit_cnt_t bit_cnt_next;
    logic         chan_end;

    // right channel held for the second half of the frame
    sample_t      right_q;
    // outgoing bits, msb at the top
    sample_t      shift_q;

    // count in the data part of the slot
    logic         data_slot;

    assign audio_sclk   = mclk_div[1];
    assign sclk_fall    = (mclk_div == 2'd3);
    assign bit_cnt_next = bit_cnt + 5'd1;
    assign chan_end     = (bit_cnt == aud_bit_cnt_t'(AUD_BITS_PER_CHANNEL - 1));
    // counts 1 .. 16 carry sample bits, count 0 is taken by chan_end
    assign data_slot    = (bit_cnt_next <= aud_bit_cnt_t'(AUD_SAMPLE_BITS));

    ////////////////////
    // clock generation
    ////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            mclk_div   <= '0;
            bit_cnt    <= '0;
            audio_lrck <= 1'b0;
        end else begin
            mclk_div <= mclk_div + 2'd1;
            if (sclk_fall) begin
                bit_cnt <= bit_cnt_next;
                // channel switch every 32 bits
                if (chan_end) begin
                    audio_lrck <= ~audio_lrck;
                end
            end
        end
    end

    ////////////////////
    // sample latch and shift
    ////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            right_q    <= '0;
            shift_q    <= '0;
            audio_dac  <= 1'b0;
            sample_req <= 1'b0;
        end else begin
            sample_req <= 1'b0;
            if (sclk_fall) begin
                // zero padding by default
                audio_dac <= 1'b0;
                if (chan_end) begin
                    if (audio_lrck) begin
                        // lrck falling, new frame starts with left
                        shift_q    <= sample_left;
                        right_q    <= sample_right;
                        sample_req <= 1'b1;
                    end else begin
                        // second half of frame
                        shift_q <= right_q;
                    end
                end else if (data_slot) begin
                    // one bit delay already spent on count 0
                    audio_dac <= shift_q[15];
                    shift_q   <= {shift_q[14:0], 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/core_out_top.sv
////////////////////
// console core output stage
// video timing, pixel formatting, i2s audio
// and input word synchronizers
////////////////////

`timescale 1ns/10ps
`default_nettype none

module core_out_top (
    input  logic                    audgen_mclk,
    input  logic                    reset_n,
    // emulator side
    input  core_out_pkg::pixel12_t  pixel,
    input  core_out_pkg::sample_t   sample_left,
    input  core_out_pkg::sample_t   sample_right,
    // asynchronous inputs
    input  core_out_pkg::key_t      cont_key,
    input  core_out_pkg::rtc_word_t rtc_word,
    // scaler video
    output core_out_pkg::rgb24_t    video_rgb,
    output logic                    video_de,
    output logic                    video_vs,
    output logic                    video_hs,
    // i2s dac
    output logic                    audio_sclk,
    output logic                    audio_lrck,
    output logic                    audio_dac,
    output logic                    sample_req,
    // synchronized words
    output core_out_pkg::key_t      cont_key_s,
    output core_out_pkg::rtc_word_t rtc_word_s
);

    import core_out_pkg::*;

    // raster decode, one clock ahead of the video outputs
    logic raw_vs;
    logic raw_hs;
    logic raw_active;

    ////////////////////
    // video
    ////////////////////

    video_timing i_video_timing (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .raw_vs      (raw_vs),
        .raw_hs      (raw_hs),
        .raw_active  (raw_active)
    );

    pixel_output i_pixel_output (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .raw_vs      (raw_vs),
        .raw_hs      (raw_hs),
        .raw_active  (raw_active),
        .pixel       (pixel),
        .video_vs    (video_vs),
        .video_hs    (video_hs),
        .video_de    (video_de),
        .video_rgb   (video_rgb)
    );

    ////////////////////
    // audio
    ////////////////////

    i2s_serializer i_i2s_serializer (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .sample_left  (sample_left),
        .sample_right (sample_right),
        .sample_req   (sample_req),
        .audio_sclk   (audio_sclk),
        .audio_lrck   (audio_lrck),
        .audio_dac    (audio_dac)
    );

    ////////////////////
    // input sync
    ////////////////////

    // controller keys
    sync_3 #(
        .WIDTH ($bits(key_t))
    ) i_sync_key (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .d           (cont_key),
        .q           (cont_key_s)
    );

    // rtc valid and bcd time
    sync_3 #(
        .WIDTH ($bits(rtc_word_t))
    ) i_sync_rtc (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .d           (rtc_word),
        .q           (rtc_word_s)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
////////////////////
// testbench clock and reset
// 4 ns mclk, reset held low for 8 cycles
////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic audgen_mclk,
    output logic reset_n
);

    // half of the 4 ns period
    always #2 audgen_mclk = ~audgen_mclk;

    initial begin
        audgen_mclk = 1'b0;
        reset_n     = 1'b0;
        // release on a rising edge, flops still see reset on that edge
        repeat (8) @(posedge audgen_mclk);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/tb_core_out.sv
////////////////////
// core output testbench
// random pixels, samples and input words into the
// output stage, checked against reference models
////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_core_out;

    import core_out_pkg::*;

    localparam int LINE_CYCLES    = int'(VID_H_TOTAL);
    localparam int FRAME_CYCLES   = int'(VID_H_TOTAL) * int'(VID_V_TOTAL);
    localparam int DE_AFTER_HS    = 7;
    // origin to first window pixel
    localparam int FIRST_DE       = int'(VID_V_BPORCH) * LINE_CYCLES + int'(VID_H_BPORCH);
    // 2.2 frames plus margin
    localparam int TIMEOUT_CYCLES = FRAME_CYCLES * 22 / 10 + 2000;

    logic        audgen_mclk;
    logic        reset_n;
    pixel12_t    pixel;
    sample_t     sample_left;
    sample_t     sample_right;
    key_t        cont_key;
    rtc_word_t   rtc_word;
    rgb24_t      video_rgb;
    logic        video_de, video_vs, video_hs;
    logic        audio_sclk, audio_lrck, audio_dac, sample_req;
    key_t        cont_key_s;
    rtc_word_t   rtc_word_s;

    // stimulus state
    logic [31:0] lfsr_state;
    logic [63:0] rnd;
    int          stim_cnt;

    // per test counters
    // 0 reset, 1 video timing, 2 pixel, 3 audio framing, 4 audio data, 5 sync
    int          err_cnt [6];
    int          chk_cnt [6];
    int          cyc;
    int          since_reset;

    // input history, sampled on falling edges
    pixel12_t    pix_hist [2];
    key_t        key_hist [3];
    rtc_word_t   rtc_hist [3];

    // video measurement
    int          last_hs, last_vs, de_run, lines_in_frame, vs_count;
    logic        de_prev, first_de_pending, run_done;

    // audio measurement
    int          last_sclk_rise, last_lrck_edge, bit_idx, words_done;
    logic        sclk_prev, lrck_prev, word_lrck;
    logic [31:0] word;
    sample_t     exp_left, exp_right, word_exp;

    tb_clock_gen i_clock_gen (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n)
    );

    core_out_top i_dut (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .pixel        (pixel),
        .sample_left  (sample_left),
        .sample_right (sample_right),
        .cont_key     (cont_key),
        .rtc_word     (rtc_word),
        .video_rgb    (video_rgb),
        .video_de     (video_de),
        .video_vs     (video_vs),
        .video_hs     (video_hs),
        .audio_sclk   (audio_sclk),
        .audio_lrck   (audio_lrck),
        .audio_dac    (audio_dac),
        .sample_req   (sample_req),
        .cont_key_s   (cont_key_s),
        .rtc_word_s   (rtc_word_s)
    );

    ////////////////////
    // random source
    ////////////////////

    // galois lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one step per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    ////////////////////
    // reference models
    ////////////////////

    // each nibble into the top of its byte
    function automatic rgb24_t expand_pixel(input pixel12_t p);
        rgb24_t c;
        c = '0;
        c[23:20] = p[11:8];
        c[15:12] = p[7:4];
        c[7:4]   = p[3:0];
        return c;
    endfunction

    // slot 0 is the delay bit, slots 1..16 the sample, rest padding
    function automatic logic [31:0] serial_word(input sample_t s);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            w[30 - i] = s[15 - i];
        end
        return w;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0: return "reset";
            1: return "video timing";
            2: return "pixel data";
            3: return "audio framing";
            4: return "audio data";
            default: return "synchronizers";
        endcase
    endfunction

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_rgb(input int t, input rgb24_t got, input rgb24_t exp,
                             input string what);
        chk_cnt[t]++;
        if (got !== exp) begin
            err_cnt[t]++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sample(input int t, input sample_t got, input sample_t exp,
                                input string what);
        chk_cnt[t]++;
        if (got !== exp) begin
            err_cnt[t]++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_key(input int t, input key_t got, input key_t exp,
                             input string what);
        chk_cnt[t]++;
        if (got !== exp) begin
            err_cnt[t]++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rtc(input int t, input rtc_word_t got, input rtc_word_t exp,
                             input string what);
        chk_cnt[t]++;
        if (got !== exp) begin
            err_cnt[t]++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // periods, run lengths and single levels
    task automatic check_count(input int t, input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        chk_cnt[t]++;
        if (got !== exp) begin
            err_cnt[t]++;
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input int t, input string what);
        err_cnt[t]++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic print_test_line(input int t);
        $display("test %s done: %0d checks, %0d errors", test_name(t), chk_cnt[t], err_cnt[t]);
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    always @(posedge audgen_mclk) begin
        rnd = take_bits(12);
        pixel <= rnd[11:0];
        // next pair once the current one is latched
        if (sample_req) begin
            rnd = take_bits(16);
            sample_left <= rnd[15:0];
            rnd = take_bits(16);
            sample_right <= rnd[15:0];
        end
        if (stim_cnt == 49) begin
            stim_cnt <= 0;
            rnd = take_bits(32);
            cont_key <= rnd[31:0];
            rnd = take_bits(33);
            rtc_word <= rnd[32:0];
        end else begin
            stim_cnt <= stim_cnt + 1;
        end
    end

    ////////////////////
    // checkers
    ////////////////////

    task automatic check_video_timing();
        if (video_hs) begin
            if (last_hs >= 0) begin
                check_count(1, cyc - last_hs, LINE_CYCLES, "hsync period");
            end
            last_hs = cyc;
        end
        if (video_vs) begin
            if (last_vs >= 0) begin
                check_count(1, cyc - last_vs, FRAME_CYCLES, "vsync period");
                check_count(1, lines_in_frame, int'(VID_V_ACTIVE), "active lines per frame");
            end
            last_vs          = cyc;
            lines_in_frame   = 0;
            first_de_pending = 1'b1;
            vs_count++;
            // two whole frames measured
            if (vs_count == 3) begin
                run_done = 1'b1;
            end
        end
        if (video_de && !de_prev) begin
            check_count(1, cyc - last_hs, DE_AFTER_HS, "data enable start after hsync");
            if (first_de_pending) begin
                check_count(1, cyc - last_vs, FIRST_DE, "first data enable after vsync");
                first_de_pending = 1'b0;
            end
            de_run = 1;
        end else if (video_de) begin
            de_run++;
        end else if (de_prev) begin
            check_count(1, de_run, int'(VID_H_ACTIVE), "data enable run length");
            lines_in_frame++;
        end
        de_prev = video_de;
    endtask

    task automatic check_audio_framing();
        if (audio_sclk && !sclk_prev) begin
            if (last_sclk_rise >= 0) begin
                check_count(3, cyc - last_sclk_rise, 4, "sclk period");
            end
            last_sclk_rise = cyc;
        end
        if (audio_lrck != lrck_prev) begin
            if (last_lrck_edge >= 0) begin
                check_count(3, cyc - last_lrck_edge, 128, "lrck half period");
            end
            last_lrck_edge = cyc;
        end
        check_count(3, sample_req, lrck_prev && !audio_lrck, "sample_req at lrck fall");
    endtask

    task automatic collect_audio_bits();
        logic [31:0] exp_word;
        // pair latched on this cycle
        if (sample_req) begin
            exp_left  = sample_left;
            exp_right = sample_right;
        end
        if (audio_sclk && !sclk_prev) begin
            // lrck changed, previous channel word complete
            if (audio_lrck != word_lrck) begin
                exp_word = serial_word(word_exp);
                check_count(4, bit_idx, AUD_BITS_PER_CHANNEL, "bits per channel");
                check_sample(4, word[30:15], exp_word[30:15], "channel sample bits");
                check_count(4, {word[31], word[14:0]}, {exp_word[31], exp_word[14:0]},
                            "delay and padding bits");
                word_exp  = audio_lrck ? exp_right : exp_left;
                word_lrck = audio_lrck;
                bit_idx   = 0;
                word      = '0;
                words_done++;
            end
            if (bit_idx < 32) begin
                word[31 - bit_idx] = audio_dac;
            end
            bit_idx++;
        end
        sclk_prev = audio_sclk;
        lrck_prev = audio_lrck;
    endtask

    always @(negedge audgen_mclk) begin
        if (since_reset == 0) begin
            check_rgb(0, video_rgb, '0, "video_rgb in reset");
            check_count(0, {video_vs, video_hs, video_de}, 0, "video levels in reset");
            check_count(0, {audio_sclk, audio_lrck, audio_dac, sample_req}, 0,
                        "audio levels in reset");
            if (reset_n) begin
                print_test_line(0);
            end
        end else begin
            check_video_timing();
            // pixel from two edges back
            if (video_de) begin
                check_rgb(2, video_rgb, expand_pixel(pix_hist[1]), "video_rgb in window");
            end else begin
                check_rgb(2, video_rgb, '0, "video_rgb outside window");
            end
            check_audio_framing();
            collect_audio_bits();
            // synchronizer pipe full three edges after release
            if (since_reset >= 3) begin
                check_key(5, cont_key_s, key_hist[2], "cont_key_s");
                check_rtc(5, rtc_word_s, rtc_hist[2], "rtc_word_s");
            end
        end
        pix_hist[1] = pix_hist[0];
        pix_hist[0] = pixel;
        key_hist[2] = key_hist[1];
        key_hist[1] = key_hist[0];
        key_hist[0] = cont_key;
        rtc_hist[2] = rtc_hist[1];
        rtc_hist[1] = rtc_hist[0];
        rtc_hist[0] = rtc_word;
        cyc++;
        if (reset_n) begin
            since_reset++;
        end
    end

    ////////////////////
    // run control
    ////////////////////

    initial begin : main_seq
        int total_err;
        int total_chk;
        lfsr_state   = 32'h495d_7b5c;
        pixel        = '0;
        sample_left  = '0;
        sample_right = '0;
        cont_key     = '0;
        rtc_word     = '0;
        stim_cnt     = 0;
        cyc          = 0;
        since_reset  = 0;
        for (int t = 0; t < 6; t++) begin
            err_cnt[t] = 0;
            chk_cnt[t] = 0;
        end
        last_hs          = -1;
        last_vs          = -1;
        de_run           = 0;
        lines_in_frame   = 0;
        vs_count         = 0;
        de_prev          = 1'b0;
        first_de_pending = 1'b0;
        run_done         = 1'b0;
        last_sclk_rise   = -1;
        last_lrck_edge   = -1;
        bit_idx          = 0;
        words_done       = 0;
        sclk_prev        = 1'b0;
        lrck_prev        = 1'b0;
        word_lrck        = 1'b0;
        word             = '0;
        exp_left         = '0;
        exp_right        = '0;
        word_exp         = '0;
        while (!run_done && cyc < TIMEOUT_CYCLES) begin
            @(negedge audgen_mclk);
            #1;
        end
        if (!run_done) begin
            $display("timeout after %0d cycles, two video frames never completed", cyc);
            $display("TESTBENCH FAILED");
        end else begin
            if (words_done < 4) begin
                report_failure(4, "too few audio channel words were checked");
            end
            for (int t = 1; t < 6; t++) begin
                print_test_line(t);
            end
            total_err = 0;
            total_chk = 0;
            for (int t = 0; t < 6; t++) begin
                total_err += err_cnt[t];
                total_chk += chk_cnt[t];
            end
            $display("tests 6, checks %0d, errors %0d", total_chk, total_err);
            if (total_err == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
src/core_out_pkg.sv
src/sync_3.sv
src/video_timing.sv
src/pixel_output.sv
src/i2s_serializer.sv
src/core_out_top.sv
verif/tb_clock_gen.sv
verif/tb_core_out.sv

// File: Bender.yml
package:
  name: core_out

sources:
  - src/core_out_pkg.sv
  - src/sync_3.sv
  - src/video_timing.sv
  - src/pixel_output.sv
  - src/i2s_serializer.sv
  - src/core_out_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_core_out.sv
